//--- design/cpuPkg.sv
package cpuPkg;

  typedef enum logic [3:0] {
    cmdNop,
    cmdSma,      // Set memory address
    cmdSrm,      // Store read data
    cmdSrmOpc,   // Store read data, target from the opcode
    cmdSmw,      // Memory write
    cmdInc16,
    cmdDec16,
    cmdSpc,      // Set PC
    cmdAluOp     // AND/XOR/OR with A, or register copy
  } uopCmdT;

  // Codes 0..7 follow the Z80 three-bit register field
  typedef enum logic [3:0] {
    selB     = 4'd0,
    selC     = 4'd1,
    selD     = 4'd2,
    selE     = 4'd3,
    selH     = 4'd4,
    selL     = 4'd5,
    selHl    = 4'd6,
    selA     = 4'd7,
    selBc    = 4'd8,
    selDe    = 4'd9,
    selPc    = 4'd10,
    selX16   = 4'd11,
    selX16Lo = 4'd12,
    selX16Hi = 4'd13,
    selNone  = 4'd14
  } regSelT;

  typedef enum logic [1:0] {
    eofNever,
    eofAlways,
    eofIfZero,
    eofIfNotZero
  } eofModeT;

  typedef struct packed {
    logic       incPc;
    eofModeT    eofMode;
    uopCmdT     cmd;
    regSelT     operand;
    logic [2:0] spare;
  } uopT;

  typedef enum logic [1:0] {
    stAfterReset,
    stStartFlow,
    stRunFlow,
    stEndFlow
  } flowStateT;

endpackage

//--- design/cpuTop.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpuTop
(
  input  logic               iClock,
  input  logic               reset,
  input  logic [`DATA_W-1:0] dataIn,
  output logic [`DATA_W-1:0] dataOut,
  output logic [`ADDR_W-1:0] mcuAddr,
  output logic               writeEnable,
  output logic               readRequest
);
  import cpuPkg::*;

  logic [`UPC_W-1:0]  uopIdx;
  logic [`UPC_W-1:0]  flowStart;
  uopT                uop;
  logic               flowEnable;
  logic [`DATA_W-1:0] opcode;
  logic               zeroFlag;
  logic               regWe;
  regSelT             writeSel;
  logic [`ADDR_W-1:0] writeData;
  logic               pcLoad;
  logic [`ADDR_W-1:0] pcData;
  logic               addrSelWe;
  regSelT             readSel;
  logic [`ADDR_W-1:0] readData;

  flowSequencer uSequencer
  (
    .iClock(iClock),
    .reset(reset),
    .dataIn(dataIn),
    .uop(uop),
    .flowStart(flowStart),
    .zeroFlag(zeroFlag),
    .uopIdx(uopIdx),
    .flowEnable(flowEnable),
    .opcode(opcode)
  );

  // Lookup sees the opcode on the bus during startFlow
  microcodeRom uRom
  (
    .uopIdx(uopIdx),
    .opcode(dataIn),
    .uop(uop),
    .flowStart(flowStart)
  );

  uopExecute uExecute
  (
    .iClock(iClock),
    .reset(reset),
    .flowEnable(flowEnable),
    .uop(uop),
    .opcode(opcode),
    .readData(readData),
    .dataIn(dataIn),
    .regWe(regWe),
    .writeSel(writeSel),
    .writeData(writeData),
    .pcLoad(pcLoad),
    .pcData(pcData),
    .addrSelWe(addrSelWe),
    .readSel(readSel),
    .writeEnable(writeEnable),
    .readRequest(readRequest),
    .zeroFlag(zeroFlag)
  );

  registerFile uRegFile
  (
    .iClock(iClock),
    .reset(reset),
    .flowEnable(flowEnable),
    .incPc(uop.incPc),
    .regWe(regWe),
    .writeSel(writeSel),
    .writeData(writeData),
    .pcLoad(pcLoad),
    .pcData(pcData),
    .addrSelWe(addrSelWe),
    .readSel(readSel),
    .readData(readData),
    .mcuAddr(mcuAddr),
    .dataOut(dataOut)
  );

endmodule

//--- design/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// --------------------
// Datapath widths
`define DATA_W        8
`define ADDR_W        16

// --------------------
// Microcode store
`define UPC_W         7
`define UOP_ROM_DEPTH 128

`define RESET_PC      16'h0000   // First opcode fetch

// Opcodes decoded by value rather than by register field
`define OP_JP         8'hC3
`define OP_JPZ        8'hCA

`endif

//--- design/flowSequencer.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module flowSequencer
(
  input  logic               iClock,
  input  logic               reset,
  input  logic [`DATA_W-1:0] dataIn,
  input  cpuPkg::uopT        uop,
  input  logic [`UPC_W-1:0]  flowStart,
  input  logic               zeroFlag,
  output logic [`UPC_W-1:0]  uopIdx,
  output logic               flowEnable,
  output logic [`DATA_W-1:0] opcode
);
  import cpuPkg::*;

  flowStateT state;
  flowStateT nextState;
  logic      endOfFlow;

  always_comb
  begin
    case (uop.eofMode)
      eofAlways:    endOfFlow = 1'b1;
      eofIfZero:    endOfFlow = zeroFlag;
      eofIfNotZero: endOfFlow = !zeroFlag;
      default:      endOfFlow = 1'b0;
    endcase
  end

  // --------------------
  // Flow FSM
  always_comb
  begin
    case (state)
      stAfterReset: nextState = stStartFlow;
      stStartFlow:  nextState = stRunFlow;
      stRunFlow:    nextState = endOfFlow ? stEndFlow : stRunFlow;
      default:      nextState = stStartFlow;
    endcase
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
      state <= stAfterReset;
    else
      state <= nextState;
  end

  assign flowEnable = (state == stRunFlow);

  always_ff @(posedge iClock)
  begin
    if (reset)
      uopIdx <= `UPC_W'(0);
    else if (state == stStartFlow)
      uopIdx <= flowStart;
    else if (state == stRunFlow)
      uopIdx <= uopIdx + `UPC_W'(1);   // One micro-op per clock
  end

  always_ff @(posedge iClock)
  begin
    if (state == stStartFlow)
      opcode <= dataIn;
  end

endmodule

//--- design/microcodeRom.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module microcodeRom
(
  input  logic [`UPC_W-1:0]  uopIdx,
  input  logic [`DATA_W-1:0] opcode,
  output cpuPkg::uopT        uop,
  output logic [`UPC_W-1:0]  flowStart
);
  import cpuPkg::*;

  localparam int flowNop   = 0;
  localparam int flowLdRn  = 1;
  localparam int flowAlu   = 5;   // Also LD r,r'
  localparam int flowLdHlR = 7;
  localparam int flowIncBc = 11;
  localparam int flowIncDe = 13;
  localparam int flowIncHl = 15;
  localparam int flowDecBc = 17;
  localparam int flowDecDe = 19;
  localparam int flowDecHl = 21;
  localparam int flowJp    = 23;
  localparam int flowJpZ   = 32;

  function automatic uopT uopWord(input logic inc, input eofModeT eof, input uopCmdT cmd,
                                  input regSelT sel);
    uopT word;
    word.incPc   = inc;
    word.eofMode = eof;
    word.cmd     = cmd;
    word.operand = sel;
    word.spare   = 3'b000;
    return word;
  endfunction

  localparam uopT fetchPc  = uopWord(1'b1, eofNever, cmdSma, selPc);
  localparam uopT fetchEnd = uopWord(1'b1, eofAlways, cmdSma, selPc);
  localparam uopT waitRead = uopWord(1'b0, eofNever, cmdNop, selNone);

  uopT romTable [`UOP_ROM_DEPTH];

  // --------------------
  // Flow table
  always_comb
  begin
    for (int i = 0; i < `UOP_ROM_DEPTH; i++)
      romTable[i] = fetchEnd;
    romTable[flowNop]       = fetchEnd;
    romTable[flowLdRn]      = fetchPc;
    romTable[flowLdRn + 1]  = waitRead;
    romTable[flowLdRn + 2]  = uopWord(1'b0, eofNever, cmdSrmOpc, selNone);
    romTable[flowLdRn + 3]  = fetchEnd;
    romTable[flowAlu]       = uopWord(1'b0, eofNever, cmdAluOp, selNone);
    romTable[flowAlu + 1]   = fetchEnd;
    // The source byte is staged in X16 before the store
    romTable[flowLdHlR]     = uopWord(1'b0, eofNever, cmdAluOp, selNone);
    romTable[flowLdHlR + 1] = uopWord(1'b0, eofNever, cmdSma, selHl);
    romTable[flowLdHlR + 2] = uopWord(1'b0, eofNever, cmdSmw, selX16Lo);
    romTable[flowLdHlR + 3] = fetchEnd;
    romTable[flowIncBc]     = uopWord(1'b0, eofNever, cmdInc16, selBc);
    romTable[flowIncBc + 1] = fetchEnd;
    romTable[flowIncDe]     = uopWord(1'b0, eofNever, cmdInc16, selDe);
    romTable[flowIncDe + 1] = fetchEnd;
    romTable[flowIncHl]     = uopWord(1'b0, eofNever, cmdInc16, selHl);
    romTable[flowIncHl + 1] = fetchEnd;
    romTable[flowDecBc]     = uopWord(1'b0, eofNever, cmdDec16, selBc);
    romTable[flowDecBc + 1] = fetchEnd;
    romTable[flowDecDe]     = uopWord(1'b0, eofNever, cmdDec16, selDe);
    romTable[flowDecDe + 1] = fetchEnd;
    romTable[flowDecHl]     = uopWord(1'b0, eofNever, cmdDec16, selHl);
    romTable[flowDecHl + 1] = fetchEnd;
    romTable[flowJp]        = fetchPc;
    romTable[flowJp + 1]    = waitRead;
    romTable[flowJp + 2]    = uopWord(1'b0, eofNever, cmdSrm, selX16Lo);
    romTable[flowJp + 3]    = fetchPc;
    romTable[flowJp + 4]    = waitRead;
    romTable[flowJp + 5]    = uopWord(1'b0, eofNever, cmdSrm, selX16Hi);
    romTable[flowJp + 6]    = uopWord(1'b0, eofNever, cmdDec16, selX16);   // Fetch adds one back
    romTable[flowJp + 7]    = uopWord(1'b0, eofNever, cmdSpc, selX16);
    romTable[flowJp + 8]    = fetchEnd;
    romTable[flowJpZ]       = fetchPc;
    romTable[flowJpZ + 1]   = waitRead;
    romTable[flowJpZ + 2]   = uopWord(1'b0, eofNever, cmdSrm, selX16Lo);
    romTable[flowJpZ + 3]   = fetchPc;
    romTable[flowJpZ + 4]   = waitRead;
    romTable[flowJpZ + 5]   = uopWord(1'b0, eofNever, cmdSrm, selX16Hi);
    romTable[flowJpZ + 6]   = uopWord(1'b0, eofNever, cmdDec16, selX16);
    // Not taken ends here with the next opcode already addressed
    romTable[flowJpZ + 7]   = uopWord(1'b1, eofIfNotZero, cmdSma, selPc);
    romTable[flowJpZ + 8]   = uopWord(1'b0, eofNever, cmdSpc, selX16);
    romTable[flowJpZ + 9]   = fetchEnd;
  end

  assign uop = romTable[uopIdx];

  // --------------------
  // Opcode lookup, first match wins
  always_comb
  begin
    flowStart = `UPC_W'(flowNop);
    casez (opcode)
      `OP_JP:       flowStart = `UPC_W'(flowJp);
      `OP_JPZ:      flowStart = `UPC_W'(flowJpZ);
      8'b00000011:  flowStart = `UPC_W'(flowIncBc);
      8'b00010011:  flowStart = `UPC_W'(flowIncDe);
      8'b00100011:  flowStart = `UPC_W'(flowIncHl);
      8'b00001011:  flowStart = `UPC_W'(flowDecBc);
      8'b00011011:  flowStart = `UPC_W'(flowDecDe);
      8'b00101011:  flowStart = `UPC_W'(flowDecHl);
      8'b00???110:
        if (opcode[5:3] != 3'b110)
          flowStart = `UPC_W'(flowLdRn);
      8'b01110???:
        if (opcode[2:0] != 3'b110)   // 0x76 is HALT
          flowStart = `UPC_W'(flowLdHlR);
      8'b01??????, 8'b10100???, 8'b10101???, 8'b10110???:
        if (opcode[2:0] != 3'b110)
          flowStart = `UPC_W'(flowAlu);
      default: ;
    endcase
  end

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module registerFile
(
  input  logic               iClock,
  input  logic               reset,
  input  logic               flowEnable,
  input  logic               incPc,
  input  logic               regWe,
  input  cpuPkg::regSelT     writeSel,
  input  logic [`ADDR_W-1:0] writeData,
  input  logic               pcLoad,
  input  logic [`ADDR_W-1:0] pcData,
  input  logic               addrSelWe,
  input  cpuPkg::regSelT     readSel,
  output logic [`ADDR_W-1:0] readData,
  output logic [`ADDR_W-1:0] mcuAddr,
  output logic [`DATA_W-1:0] dataOut
);
  import cpuPkg::*;

  logic [`DATA_W-1:0] bReg, cReg, dReg, eReg, hReg, lReg, aReg;
  logic [`ADDR_W-1:0] x16Reg;
  logic [`ADDR_W-1:0] pcReg;
  regSelT             addrSel;

  // 8-bit selects return fill in the upper byte
  function automatic logic [`ADDR_W-1:0] readMux(input regSelT sel,
                                                 input logic [`DATA_W-1:0] fill);
    case (sel)
      selB:     return {fill, bReg};
      selC:     return {fill, cReg};
      selD:     return {fill, dReg};
      selE:     return {fill, eReg};
      selH:     return {fill, hReg};
      selL:     return {fill, lReg};
      selA:     return {fill, aReg};
      selHl:    return {hReg, lReg};
      selBc:    return {bReg, cReg};
      selDe:    return {dReg, eReg};
      selPc:    return pcReg;
      selX16:   return x16Reg;
      selX16Lo: return {fill, x16Reg[`DATA_W-1:0]};
      selX16Hi: return {fill, x16Reg[`ADDR_W-1:`DATA_W]};
      default:  return '0;
    endcase
  endfunction

  // --------------------
  // Register writes, pairs split high and low
  always_ff @(posedge iClock)
  begin
    if (regWe)
    begin
      case (writeSel)
        selB:     bReg <= writeData[`DATA_W-1:0];
        selC:     cReg <= writeData[`DATA_W-1:0];
        selD:     dReg <= writeData[`DATA_W-1:0];
        selE:     eReg <= writeData[`DATA_W-1:0];
        selH:     hReg <= writeData[`DATA_W-1:0];
        selL:     lReg <= writeData[`DATA_W-1:0];
        selA:     aReg <= writeData[`DATA_W-1:0];
        selHl:    {hReg, lReg} <= writeData;
        selBc:    {bReg, cReg} <= writeData;
        selDe:    {dReg, eReg} <= writeData;
        selX16:   x16Reg <= writeData;
        selX16Lo: x16Reg[`DATA_W-1:0] <= writeData[`DATA_W-1:0];
        selX16Hi: x16Reg[`ADDR_W-1:`DATA_W] <= writeData[`DATA_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
      pcReg <= `RESET_PC;
    else if (pcLoad)
      pcReg <= pcData;
    else if (incPc && flowEnable)
      pcReg <= pcReg + `ADDR_W'(1);
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
      addrSel <= selPc;
    else if (addrSelWe)
      addrSel <= readSel;
  end

  // --------------------
  // Read paths
  always_comb
    readData = readMux(readSel, aReg);

  always_comb
    mcuAddr = readMux(addrSel, `DATA_W'(0));   // Zero-extended as an address

  assign dataOut = readData[`DATA_W-1:0];

endmodule

//--- design/uopExecute.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module uopExecute
(
  input  logic               iClock,
  input  logic               reset,
  input  logic               flowEnable,
  input  cpuPkg::uopT        uop,
  input  logic [`DATA_W-1:0] opcode,
  input  logic [`ADDR_W-1:0] readData,
  input  logic [`DATA_W-1:0] dataIn,
  output logic               regWe,
  output cpuPkg::regSelT     writeSel,
  output logic [`ADDR_W-1:0] writeData,
  output logic               pcLoad,
  output logic [`ADDR_W-1:0] pcData,
  output logic               addrSelWe,
  output cpuPkg::regSelT     readSel,
  output logic               writeEnable,
  output logic               readRequest,
  output logic               zeroFlag
);
  import cpuPkg::*;

  regSelT             srcSel;
  regSelT             destSel;
  logic [`DATA_W-1:0] accum;
  logic [`DATA_W-1:0] srcByte;
  logic [`DATA_W-1:0] aluResult;
  logic               isLogic;

  // Source in opcode[2:0], destination in opcode[5:3]
  assign srcSel  = regSelT'({1'b0, opcode[2:0]});
  assign destSel = (opcode[5:3] == 3'b110) ? selX16Lo : regSelT'({1'b0, opcode[5:3]});
  assign accum   = readData[`ADDR_W-1:`DATA_W];   // A comes back in the upper byte
  assign srcByte = readData[`DATA_W-1:0];
  assign isLogic = (opcode[7:6] == 2'b10);

  assign readSel = (uop.cmd == cmdAluOp) ? srcSel : uop.operand;
  assign pcData  = readData;

  always_comb
  begin
    case (opcode[7:3])
      5'b10100: aluResult = accum & srcByte;
      5'b10101: aluResult = accum ^ srcByte;
      5'b10110: aluResult = accum | srcByte;
      default:  aluResult = srcByte;        // LD r,r'
    endcase
  end

  // --------------------
  // Command decode
  always_comb
  begin
    regWe       = 1'b0;
    writeSel    = uop.operand;
    writeData   = readData;
    pcLoad      = 1'b0;
    addrSelWe   = 1'b0;
    writeEnable = 1'b0;
    if (flowEnable)
    begin
      case (uop.cmd)
        cmdSma:   addrSelWe = 1'b1;
        cmdSrm:
        begin
          regWe     = 1'b1;
          writeData = `ADDR_W'(dataIn);
        end
        cmdSrmOpc:
        begin
          regWe     = 1'b1;
          writeSel  = destSel;
          writeData = `ADDR_W'(dataIn);
        end
        cmdSmw:   writeEnable = 1'b1;
        cmdInc16:
        begin
          regWe     = 1'b1;
          writeData = readData + `ADDR_W'(1);
        end
        cmdDec16:
        begin
          regWe     = 1'b1;
          writeData = readData - `ADDR_W'(1);
        end
        cmdSpc:   pcLoad = 1'b1;
        cmdAluOp:
        begin
          regWe     = 1'b1;
          writeSel  = isLogic ? selA : destSel;
          writeData = `ADDR_W'(aluResult);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (reset)
    begin
      readRequest <= 1'b0;
      zeroFlag    <= 1'b0;
    end
    else
    begin
      readRequest <= flowEnable && (uop.cmd == cmdSma);
      if (flowEnable && (uop.cmd == cmdAluOp) && isLogic)
        zeroFlag <= (aluResult == '0);    // Copies leave Z alone
    end
  end

endmodule

//--- dv/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// --------------------
// Program image from address 0x0000
localparam int progLen = 118;
localparam logic [7:0] progBytes [progLen] = '{
  8'h26, 8'h80, 8'h2E, 8'h10, 8'h06, 8'h11, 8'h70, 8'h23,   // 00 HL = 8010
  8'h0E, 8'h22, 8'h71, 8'h23, 8'h16, 8'h33, 8'h72, 8'h23,   // 08
  8'h1E, 8'h44, 8'h73, 8'h3E, 8'h55, 8'h23, 8'h77, 8'h74,   // 10
  8'h75, 8'h47, 8'h23, 8'h70, 8'h4A, 8'h71, 8'h58, 8'h73,   // 18 LD r,r'
  8'h3E, 8'hF0, 8'h06, 8'h3C, 8'hA0, 8'h77, 8'hA8, 8'h77,   // 20 AND, XOR
  8'hB1, 8'h77, 8'hCA, 8'hE0, 8'h00, 8'h77, 8'h16, 8'hC0,   // 28 OR, JP Z not taken
  8'hA2, 8'hCA, 8'h38, 8'h00, 8'h3E, 8'hEE, 8'h77, 8'h00,   // 30 JP Z taken
  8'h77, 8'h26, 8'h00, 8'h2E, 8'h00, 8'h2B, 8'h06, 8'hA1,   // 38
  8'h70, 8'h23, 8'h0E, 8'hA2, 8'h71, 8'h06, 8'h00, 8'h0E,   // 40
  8'h00, 8'h0B, 8'h60, 8'h69, 8'h3E, 8'hB1, 8'h77, 8'h16,   // 48 BC wraps down
  8'hFF, 8'h1E, 8'hFF, 8'h13, 8'h62, 8'h6B, 8'h3E, 8'hB2,   // 50 DE wraps up
  8'h77, 8'h1B, 8'h62, 8'h6B, 8'h3E, 8'hB3, 8'h77, 8'h03,   // 58
  8'h60, 8'h69, 8'h3E, 8'hB4, 8'h77, 8'h26, 8'h81, 8'h2E,   // 60
  8'h00, 8'h3E, 8'hC1, 8'hC3, 8'h70, 8'h00, 8'h77, 8'h00,   // 68 JP over a store
  8'h3E, 8'hC2, 8'h77, 8'hC3, 8'h73, 8'h00                  // 70 Loops on itself
};

// Landing spot of the JP Z at 0x002A that stores EE and spins
localparam logic [15:0] trapAddr = 16'h00E0;
localparam int trapLen = 6;
localparam logic [7:0] trapBytes [trapLen] = '{8'h3E, 8'hEE, 8'h77, 8'hC3, 8'hE3, 8'h00};

// --------------------
// Expected stores as {address, data} in bus order
localparam int writeCount = 22;
localparam logic [23:0] expWrites [writeCount] = '{
  {16'h8010, 8'h11}, {16'h8011, 8'h22}, {16'h8012, 8'h33}, {16'h8013, 8'h44},
  {16'h8014, 8'h55}, {16'h8014, 8'h80}, {16'h8014, 8'h14},
  {16'h8015, 8'h55}, {16'h8015, 8'h33}, {16'h8015, 8'h55},   // Copies
  {16'h8015, 8'h30}, {16'h8015, 8'h0C}, {16'h8015, 8'h3F},   // AND, XOR, OR
  {16'h8015, 8'h3F},                                         // Fall through
  {16'h8015, 8'h00},                                         // Jump target
  {16'hFFFF, 8'hA1}, {16'h0000, 8'hA2}, {16'hFFFF, 8'hB1}, {16'h0000, 8'hB2},
  {16'hFFFF, 8'hB3}, {16'h0000, 8'hB4},
  {16'h8100, 8'hC2}
};

// Read requests seen since the previous store including the store's own address
localparam int readCounts [writeCount] = '{
  7, 5, 5, 5, 5, 2, 2, 4, 3, 3, 7, 3, 3, 5, 9, 9, 5, 11, 11, 7, 7, 13
};

`endif

//--- dv/tbCpu.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module tbCpu;

`include "tbProgram.svh"

  localparam int writeTimeout = 200;   // Cycles allowed between two stores

  logic               iClock;
  logic               reset;
  logic [`DATA_W-1:0] dataIn = '0;
  logic [`DATA_W-1:0] dataOut;
  logic [`ADDR_W-1:0] mcuAddr;
  logic               writeEnable;
  logic               readRequest;

  logic [`DATA_W-1:0] mem [1 << `ADDR_W];

  cpuTop u_dut
  (
    .iClock(iClock),
    .reset(reset),
    .dataIn(dataIn),
    .dataOut(dataOut),
    .mcuAddr(mcuAddr),
    .writeEnable(writeEnable),
    .readRequest(readRequest)
  );

  initial
  begin
    iClock = 1'b0;
    forever #10 iClock = ~iClock;
  end

  // --------------------
  // Memory model with data one edge behind the address
  always @(posedge iClock)
  begin
    dataIn <= mem[mcuAddr];
    if (writeEnable)
      mem[mcuAddr] <= dataOut;
  end

  task automatic loadMemory();
    for (int a = 0; a < (1 << `ADDR_W); a++)
      mem[a] <= `DATA_W'((a >> 8) ^ a ^ 'h5A);   // Background pattern
    for (int i = 0; i < progLen; i++)
      mem[i] <= progBytes[i];
    for (int i = 0; i < trapLen; i++)
      mem[int'(trapAddr) + i] <= trapBytes[i];
  endtask

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Sampled at the falling edge where writeEnable is stable for its one cycle
  task automatic waitForWrite(input int index, output int requests);
    int cycles;
    cycles = 0;
    requests = 0;
    @(negedge iClock);
    while (writeEnable !== 1'b1)
    begin
      if (readRequest === 1'b1)
        requests++;
      if (cycles >= writeTimeout)
      begin
        $display("Timeout: store %0d to address %h never happened", index,
                 expWrites[index][23:8]);
        $display("Test failures found");
        $fatal(1, "No memory write within the timeout");
      end
      cycles++;
      @(negedge iClock);
    end
    if (readRequest === 1'b1)
      requests++;   // Cycle of the store itself
  endtask

  initial
  begin
    int requests;
    reset <= 1'b1;
    loadMemory();
    repeat (10) @(posedge iClock);
    reset <= 1'b0;

    // afterReset and startFlow both address the reset PC
    repeat (2)
    begin
      @(negedge iClock);
      checkValue(mcuAddr, `RESET_PC, "fetch address after reset");
      checkValue(16'(writeEnable), 16'h0000, "writeEnable before the first fetch");
      checkValue(16'(readRequest), 16'h0000, "readRequest before the first fetch");
    end

    // --------------------
    // Walk the expected stores
    for (int i = 0; i < writeCount; i++)
    begin
      waitForWrite(i, requests);
      checkValue(mcuAddr, expWrites[i][23:8], $sformatf("store %0d address", i));
      checkValue(16'(dataOut), 16'(expWrites[i][7:0]), $sformatf("store %0d data", i));
      checkValue(16'(requests), 16'(readCounts[i]), $sformatf("store %0d read requests", i));
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary -Wno-fatal --top-module tbCpu -f src.f -Mdir "$buildDir" -o tbCpu
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

"./$buildDir/tbCpu" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Test failures found" "$logFile"; then
  echo "RESULT: FAIL"
  exit 1
fi
if [ "$simStatus" -ne 0 ]; then
  echo "ERROR: simulation exited with status $simStatus"
  exit 1
fi
echo "RESULT: PASS"

//--- src.f
+incdir+design
+incdir+dv
design/cpuPkg.sv
design/microcodeRom.sv
design/flowSequencer.sv
design/uopExecute.sv
design/registerFile.sv
design/cpuTop.sv
dv/tbCpu.sv
